/* sources.f */
+incdir+bench
verilog/l1d_cfg_pkg.sv
verilog/l1d_msg_pkg.sv
verilog/l1d_port_decode.sv
verilog/l1d_array.sv
verilog/l1d_resp_format.sv
verilog/l1d_access_top.sv
bench/l1d_access_tb.sv

/* Bender.yml */
package:
  name: l1d_access

sources:
  - verilog/l1d_cfg_pkg.sv
  - verilog/l1d_msg_pkg.sv
  - verilog/l1d_port_decode.sv
  - verilog/l1d_array.sv
  - verilog/l1d_resp_format.sv
  - verilog/l1d_access_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/l1d_access_tb.sv

/* bench/l1d_ref_model.svh */
// L1D reference model
// Behavioural copy of the two-way array and the expected walker and
// snoop responses for the testbench

`ifndef L1D_REF_MODEL_SVH
`define L1D_REF_MODEL_SVH

logic [TAG_W-1:0] m_tag   [SETS][WAYS];
line_u            m_line  [SETS][WAYS];
logic             m_valid [SETS][WAYS];

function automatic void model_clear();
  for (int s = 0; s < SETS; s++) begin
    for (int w = 0; w < WAYS; w++) begin
      m_valid[s][w] = 1'b0;
    end
  end
endfunction

// Way mask of valid lines with a matching tag
function automatic logic [WAYS-1:0] model_lookup(input logic [PADDR_W-1:0] a);
  logic [WAYS-1:0] hits;
  logic [INDEX_W-1:0] idx;
  idx  = a[OFFSET_W +: INDEX_W];
  hits = '0;
  for (int w = 0; w < WAYS; w++) begin
    hits[w] = m_valid[idx][w] && (m_tag[idx][w] == a[PADDR_W-1 -: TAG_W]);
  end
  return hits;
endfunction

function automatic ptw_resp_t expect_ptw(input ptw_req_t p, input snoop_req_t s,
                                         input fill_req_t f);
  ptw_resp_t r;
  logic [WAYS-1:0] hits;
  r = '0;
  if (p.valid) begin
    hits    = model_lookup(p.paddr);
    r.valid = 1'b1;
    if (s.valid || f.valid) begin
      r.status = STATUS_CONFLICT;
    end else if (hits != '0) begin
      r.status = STATUS_HIT;
      // With two ways the upper mask bit is the way number
      r.data   = m_line[p.paddr[7:4]][hits[1]].words[p.paddr[3:2]];
    end else begin
      r.status = STATUS_MISS;
    end
  end
  return r;
endfunction

function automatic snoop_resp_t expect_snoop(input snoop_req_t s);
  snoop_resp_t r;
  logic [WAYS-1:0] hits;
  r = '0;
  if (s.valid) begin
    r.valid = 1'b1;
    if (s.cmd == SNOOP_READ) begin
      hits   = model_lookup(s.paddr);
      r.ways = hits;
      if (hits != '0) begin
        r.status = STATUS_HIT;
        r.be     = '1;
        r.data   = m_line[s.paddr[7:4]][hits[1]];
      end else begin
        r.status = STATUS_MISS;
      end
    end
  end
  return r;
endfunction

// Refill is applied before invalidate
function automatic void model_write(input fill_req_t f, input snoop_req_t s);
  if (f.valid) begin
    m_tag[f.paddr[7:4]][f.way]   = f.paddr[PADDR_W-1 -: TAG_W];
    m_line[f.paddr[7:4]][f.way]  = f.data;
    m_valid[f.paddr[7:4]][f.way] = 1'b1;
  end
  if (s.valid && (s.cmd == SNOOP_INVALID)) begin
    for (int w = 0; w < WAYS; w++) begin
      if (s.ways[w]) begin
        m_valid[s.paddr[7:4]][w] = 1'b0;
      end
    end
  end
endfunction

`endif

/* bench/l1d_access_tb.sv */
// L1D access path testbench
// Directed and random walker, snoop and refill traffic, checked every
// cycle against a behavioural cache model

module l1d_access_tb;
  import l1d_cfg_pkg::*;
  import l1d_msg_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 64;
  localparam int RANDOM_CYCLES   = 4000;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 200;
  localparam logic [TAG_W-1:0] TAG_BASE = 24'h5a3c00;

  logic        clk;
  logic        reset_n;
  logic        reset_drive;
  ptw_req_t    drv_ptw;
  snoop_req_t  drv_snoop;
  fill_req_t   drv_fill;
  ptw_resp_t   dut_ptw_resp;
  snoop_resp_t dut_snoop_resp;

  ptw_resp_t   exp_ptw;
  snoop_resp_t exp_snoop;
  ptw_resp_t   last_ptw;
  snoop_resp_t last_snoop;
  integer      seed;
  int          errors;
  int          test_errors;
  int          checks;

  logic [PADDR_W-1:0] addr_a;
  logic [PADDR_W-1:0] addr_b;
  line_u              line_a;

  `include "l1d_ref_model.svh"

  l1d_access_top dut_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_ptw_req    (drv_ptw),
    .i_snoop_req  (drv_snoop),
    .i_fill       (drv_fill),
    .o_ptw_resp   (dut_ptw_resp),
    .o_snoop_resp (dut_snoop_resp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_ptw_resp(input ptw_resp_t got, input ptw_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("** Error: o_ptw_resp got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_snoop_resp(input snoop_resp_t got, input snoop_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("** Error: o_snoop_resp got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic logic [PADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [INDEX_W-1:0] idx,
                                                   input logic [OFFSET_W-1:0] off);
    return {tag, idx, off};
  endfunction

  // Few tags per set so that lookups hit often
  function automatic logic [PADDR_W-1:0] pool_addr();
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  idx;
    logic [OFFSET_W-1:0] off;
    tag = TAG_BASE + TAG_W'($random(seed) & 3);
    idx = INDEX_W'($random(seed));
    off = OFFSET_W'($random(seed));
    return make_addr(tag, idx, off);
  endfunction

  function automatic line_u rand_line();
    line_u r;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      r.words[i] = $random(seed);
    end
    return r;
  endfunction

  function automatic ptw_req_t ptw_read_req(input logic [PADDR_W-1:0] a);
    return ptw_req_t'{1'b1, a};
  endfunction

  function automatic snoop_req_t snoop_cmd_req(input snoop_cmd_t c, input logic [WAYS-1:0] w,
                                               input logic [PADDR_W-1:0] a);
    return snoop_req_t'{1'b1, c, w, a};
  endfunction

  function automatic fill_req_t fill_line_req(input logic [PADDR_W-1:0] a, input logic way,
                                              input line_u d);
    return fill_req_t'{1'b1, way, a, d};
  endfunction

  // Drive one cycle and check the previous cycle's responses
  task automatic run_cycle(input ptw_req_t p, input snoop_req_t s, input fill_req_t f);
    @(posedge clk);
    reset_n   <= reset_drive;
    drv_ptw   <= p;
    drv_snoop <= s;
    drv_fill  <= f;
    @(negedge clk);
    last_ptw   = dut_ptw_resp;
    last_snoop = dut_snoop_resp;
    check_ptw_resp(dut_ptw_resp, exp_ptw);
    check_snoop_resp(dut_snoop_resp, exp_snoop);
    exp_ptw   = expect_ptw(p, s, f);
    exp_snoop = expect_snoop(s);
    model_write(f, s);
  endtask

  task automatic ptw_read_expect(input logic [PADDR_W-1:0] a, input ptw_resp_t exp);
    run_cycle(ptw_read_req(a), '0, '0);
    run_cycle('0, '0, '0);
    check_ptw_resp(last_ptw, exp);
  endtask

  task automatic snoop_expect(input snoop_req_t s, input snoop_resp_t exp);
    run_cycle('0, s, '0);
    run_cycle('0, '0, '0);
    check_snoop_resp(last_snoop, exp);
  endtask

  task automatic random_cycle();
    ptw_req_t   p;
    snoop_req_t s;
    fill_req_t  f;
    logic [WAYS-1:0] hits;
    p = ptw_read_req(pool_addr());
    p.valid = ($random(seed) & 1) != 0;
    s = snoop_cmd_req((($random(seed) & 3) == 0) ? SNOOP_INVALID : SNOOP_READ,
                      WAYS'($random(seed)), pool_addr());
    s.valid = ($random(seed) & 3) == 0;
    f = fill_line_req(pool_addr(), 1'($random(seed)), rand_line());
    f.valid = ($random(seed) & 3) == 0;
    // Refill a resident tag into its own way, never into both ways
    hits = model_lookup(f.paddr);
    if (hits != '0) begin
      f.way = hits[1];
    end
    run_cycle(p, s, f);
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    seed        = 3;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    reset_n     = 1'b0;
    reset_drive = 1'b0;
    drv_ptw     = '0;
    drv_snoop   = '0;
    drv_fill    = '0;
    exp_ptw     = '0;
    exp_snoop   = '0;
    model_clear();

    repeat (RESET_CYCLES) run_cycle('0, '0, '0);
    reset_drive = 1'b1;
    run_cycle('0, '0, '0);
    ptw_read_expect(pool_addr(), ptw_resp_t'{1'b1, STATUS_MISS, '0});
    end_test("reset");

    addr_a = make_addr(TAG_BASE, 4'd5, 4'd0);
    line_a = rand_line();
    run_cycle('0, '0, fill_line_req(addr_a, 1'b0, line_a));
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      ptw_read_expect(addr_a + 4 * w, ptw_resp_t'{1'b1, STATUS_HIT, line_a.words[w]});
    end
    ptw_read_expect(make_addr(TAG_BASE + 1, 4'd5, 4'd0), ptw_resp_t'{1'b1, STATUS_MISS, '0});
    end_test("fill_then_read");

    run_cycle(ptw_read_req(addr_a), snoop_cmd_req(SNOOP_READ, '0, addr_a), '0);
    run_cycle(ptw_read_req(addr_a), '0,
              fill_line_req(make_addr(TAG_BASE + 2, 4'd7, 4'd0), 1'b1, rand_line()));
    check_ptw_resp(last_ptw, ptw_resp_t'{1'b1, STATUS_CONFLICT, '0});
    run_cycle('0, '0, '0);
    check_ptw_resp(last_ptw, ptw_resp_t'{1'b1, STATUS_CONFLICT, '0});
    end_test("conflict");

    snoop_expect(snoop_cmd_req(SNOOP_READ, '0, addr_a),
                 snoop_resp_t'{1'b1, STATUS_HIT, 2'b01, {LINE_B_W{1'b1}}, line_a});
    snoop_expect(snoop_cmd_req(SNOOP_READ, '0, make_addr(TAG_BASE + 3, 4'd5, 4'd8)),
                 snoop_resp_t'{1'b1, STATUS_MISS, '0, '0, '0});
    end_test("snoop_read");

    snoop_expect(snoop_cmd_req(SNOOP_INVALID, 2'b01, addr_a),
                 snoop_resp_t'{1'b1, STATUS_NONE, '0, '0, '0});
    ptw_read_expect(addr_a, ptw_resp_t'{1'b1, STATUS_MISS, '0});
    snoop_expect(snoop_cmd_req(SNOOP_READ, '0, addr_a),
                 snoop_resp_t'{1'b1, STATUS_MISS, '0, '0, '0});
    addr_b = make_addr(TAG_BASE + 3, 4'd9, 4'd4);
    run_cycle('0, snoop_cmd_req(SNOOP_INVALID, 2'b10, addr_b),
              fill_line_req(addr_b, 1'b1, rand_line()));
    ptw_read_expect(addr_b, ptw_resp_t'{1'b1, STATUS_MISS, '0});
    end_test("snoop_invalidate");

    repeat (RANDOM_CYCLES) random_cycle();
    run_cycle('0, '0, '0);
    end_test("random_mix");

    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verilog/l1d_access_top.sv */
// L1D shared access path
// Walker read port and snoop port in front of a small two-way data array,
// answering every request one cycle later

module l1d_access_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  l1d_msg_pkg::ptw_req_t    i_ptw_req,
  input  l1d_msg_pkg::snoop_req_t  i_snoop_req,
  input  l1d_msg_pkg::fill_req_t   i_fill,
  output l1d_msg_pkg::ptw_resp_t   o_ptw_resp,
  output l1d_msg_pkg::snoop_resp_t o_snoop_resp
);
  import l1d_msg_pkg::*;

  arr_rd_req_t  w_arr_rd_req;
  arr_wr_req_t  w_arr_wr_req;
  arr_rd_resp_t w_arr_rd_resp;
  s0_tag_t      w_s0_tag;

  // ----------------------------------------
  // Stage 0: port decode and array access
  // ----------------------------------------
  l1d_port_decode u_port_decode (
    .i_ptw_req    (i_ptw_req),
    .i_snoop_req  (i_snoop_req),
    .i_fill       (i_fill),
    .o_arr_rd_req (w_arr_rd_req),
    .o_arr_wr_req (w_arr_wr_req),
    .o_s0_tag     (w_s0_tag)
  );

  l1d_array u_array (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_req  (w_arr_rd_req),
    .i_wr_req  (w_arr_wr_req),
    .o_rd_resp (w_arr_rd_resp)
  );

  // ----------------------------------------
  // Stage 1: responses
  // ----------------------------------------
  l1d_resp_format u_resp_format (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_s0_tag     (w_s0_tag),
    .i_rd_resp    (w_arr_rd_resp),
    .o_ptw_resp   (o_ptw_resp),
    .o_snoop_resp (o_snoop_resp)
  );

endmodule

/* verilog/l1d_resp_format.sv */
// L1D response formatting
// Registers the request context and turns the array lookup into walker
// and snoop responses one cycle after the request

module l1d_resp_format (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  l1d_msg_pkg::s0_tag_t      i_s0_tag,
  input  l1d_msg_pkg::arr_rd_resp_t i_rd_resp,
  output l1d_msg_pkg::ptw_resp_t    o_ptw_resp,
  output l1d_msg_pkg::snoop_resp_t  o_snoop_resp
);
  import l1d_cfg_pkg::*;
  import l1d_msg_pkg::*;

  s0_tag_t r_s1_tag;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_tag <= '0;
    end else begin
      r_s1_tag <= i_s0_tag;
    end
  end

  // ----------------------------------------
  // Walker response
  // ----------------------------------------
  always_comb begin
    o_ptw_resp       = '0;
    o_ptw_resp.valid = r_s1_tag.ptw_valid;
    if (r_s1_tag.ptw_valid) begin
      if (r_s1_tag.ptw_conflict) begin
        o_ptw_resp.status = STATUS_CONFLICT;
      end else if (i_rd_resp.hit) begin
        o_ptw_resp.status = STATUS_HIT;
        o_ptw_resp.data   = i_rd_resp.data.words[r_s1_tag.word_sel];
      end else if (i_rd_resp.miss) begin
        o_ptw_resp.status = STATUS_MISS;
      end
    end
  end

  // ----------------------------------------
  // Snoop response
  // ----------------------------------------
  // Invalidate answers with NONE and empty fields
  always_comb begin
    o_snoop_resp       = '0;
    o_snoop_resp.valid = r_s1_tag.snoop_valid;
    if (r_s1_tag.snoop_valid && r_s1_tag.snoop_rd) begin
      o_snoop_resp.ways = i_rd_resp.hit_ways;
      if (i_rd_resp.hit) begin
        o_snoop_resp.status = STATUS_HIT;
        o_snoop_resp.be     = {LINE_B_W{1'b1}};
        o_snoop_resp.data   = i_rd_resp.data;
      end else if (i_rd_resp.miss) begin
        o_snoop_resp.status = STATUS_MISS;
      end
    end
  end

  // Walker and snoop read can never share one lookup
  a_single_reader : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_ptw_resp.valid &&
      ((o_ptw_resp.status == STATUS_HIT) || (o_ptw_resp.status == STATUS_MISS)) &&
      o_snoop_resp.valid && r_s1_tag.snoop_rd));

endmodule

/* verilog/l1d_array.sv */
// L1D two-way data array
// Tag, valid and line storage per set and way, with a lookup whose result
// is registered and a write port for line refill and invalidate

module l1d_array (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  l1d_msg_pkg::arr_rd_req_t  i_rd_req,
  input  l1d_msg_pkg::arr_wr_req_t  i_wr_req,
  output l1d_msg_pkg::arr_rd_resp_t o_rd_resp
);
  import l1d_cfg_pkg::*;
  import l1d_msg_pkg::*;

  logic [TAG_W-1:0]            r_tag  [SETS][WAYS];
  line_u                       r_data [SETS][WAYS];
  logic [SETS-1:0][WAYS-1:0]   r_valid;

  logic [INDEX_W-1:0] w_rd_idx;
  logic [TAG_W-1:0]   w_rd_tag;
  logic [INDEX_W-1:0] w_fill_idx;
  logic [TAG_W-1:0]   w_fill_tag;
  logic [INDEX_W-1:0] w_inv_idx;

  logic [WAYS-1:0] w_hit_ways;
  line_u           w_hit_line;

  logic            r_hit;
  logic            r_miss;
  logic [WAYS-1:0] r_hit_ways;
  line_u           r_hit_line;

  assign w_rd_idx   = i_rd_req.paddr[OFFSET_W +: INDEX_W];
  assign w_rd_tag   = i_rd_req.paddr[OFFSET_W+INDEX_W +: TAG_W];
  assign w_fill_idx = i_wr_req.fill_paddr[OFFSET_W +: INDEX_W];
  assign w_fill_tag = i_wr_req.fill_paddr[OFFSET_W+INDEX_W +: TAG_W];
  assign w_inv_idx  = i_wr_req.inv_paddr[OFFSET_W +: INDEX_W];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_wr_req.fill_valid) begin
      r_tag[w_fill_idx][i_wr_req.fill_way]  <= w_fill_tag;
      r_data[w_fill_idx][i_wr_req.fill_way] <= i_wr_req.fill_data;
    end
  end

  // Invalidate is written last so it overrides a refill of the same line
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
          if (i_wr_req.fill_valid && (w_fill_idx == s) && (i_wr_req.fill_way == w)) begin
            r_valid[s][w] <= 1'b1;
          end
          if (i_wr_req.inv_valid && (w_inv_idx == s) && i_wr_req.inv_ways[w]) begin
            r_valid[s][w] <= 1'b0;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Lookup
  // ----------------------------------------
  always_comb begin
    w_hit_ways = '0;
    w_hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (i_rd_req.valid && r_valid[w_rd_idx][w] && (r_tag[w_rd_idx][w] == w_rd_tag)) begin
        w_hit_ways[w]   = 1'b1;
        w_hit_line.line = w_hit_line.line | r_data[w_rd_idx][w].line;
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hit      <= 1'b0;
      r_miss     <= 1'b0;
      r_hit_ways <= '0;
    end else begin
      r_hit      <= |w_hit_ways;
      r_miss     <= i_rd_req.valid & ~(|w_hit_ways);
      r_hit_ways <= w_hit_ways;
    end
  end

  always_ff @(posedge i_clk) begin
    r_hit_line <= w_hit_line;
  end

  assign o_rd_resp.hit      = r_hit;
  assign o_rd_resp.miss     = r_miss;
  assign o_rd_resp.hit_ways = r_hit_ways;
  assign o_rd_resp.data     = r_hit_line;

  // One tag lives in at most one way of a set
  a_hit_onehot : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_rd_resp.hit_ways));

endmodule

/* verilog/l1d_port_decode.sv */
// L1D port decode
// Splits snoop commands into read or invalidate, grants the single array
// read port and merges refill and invalidate into one write request

module l1d_port_decode (
  input  l1d_msg_pkg::ptw_req_t    i_ptw_req,
  input  l1d_msg_pkg::snoop_req_t  i_snoop_req,
  input  l1d_msg_pkg::fill_req_t   i_fill,
  output l1d_msg_pkg::arr_rd_req_t o_arr_rd_req,
  output l1d_msg_pkg::arr_wr_req_t o_arr_wr_req,
  output l1d_msg_pkg::s0_tag_t     o_s0_tag
);
  import l1d_cfg_pkg::*;
  import l1d_msg_pkg::*;

  logic w_snoop_rd;
  logic w_snoop_inv;
  logic w_ptw_conflict;
  logic w_ptw_grant;

  // ----------------------------------------
  // Snoop command decode
  // ----------------------------------------
  assign w_snoop_rd  = i_snoop_req.valid & (i_snoop_req.cmd == SNOOP_READ);
  assign w_snoop_inv = i_snoop_req.valid & (i_snoop_req.cmd == SNOOP_INVALID);

  // ----------------------------------------
  // Read port grant
  // ----------------------------------------
  // Walker loses against any snoop or refill in the same cycle
  assign w_ptw_conflict = i_ptw_req.valid & (i_snoop_req.valid | i_fill.valid);
  assign w_ptw_grant    = i_ptw_req.valid & ~w_ptw_conflict;

  assign o_arr_rd_req.valid = w_snoop_rd | w_ptw_grant;
  assign o_arr_rd_req.paddr = w_snoop_rd ? i_snoop_req.paddr : i_ptw_req.paddr;

  // ----------------------------------------
  // Write request
  // ----------------------------------------
  assign o_arr_wr_req.fill_valid = i_fill.valid;
  assign o_arr_wr_req.fill_way   = i_fill.way;
  assign o_arr_wr_req.fill_paddr = i_fill.paddr;
  assign o_arr_wr_req.fill_data  = i_fill.data;
  assign o_arr_wr_req.inv_valid  = w_snoop_inv;
  assign o_arr_wr_req.inv_ways   = i_snoop_req.ways;
  assign o_arr_wr_req.inv_paddr  = i_snoop_req.paddr;

  // Context for the response stage
  assign o_s0_tag.ptw_valid    = i_ptw_req.valid;
  assign o_s0_tag.ptw_conflict = w_ptw_conflict;
  assign o_s0_tag.snoop_valid  = i_snoop_req.valid;
  assign o_s0_tag.snoop_rd     = w_snoop_rd;
  // Word index is the upper two bits of the line offset
  assign o_s0_tag.word_sel     = i_ptw_req.paddr[OFFSET_W-1 -: WORD_SEL_W];

endmodule

/* verilog/l1d_msg_pkg.sv */
// L1 data cache access messages
// Request, response and status types exchanged between the walker port,
// the snoop port and the data array

package l1d_msg_pkg;
  import l1d_cfg_pkg::*;

  typedef enum logic [1:0] {
    STATUS_NONE,
    STATUS_HIT,
    STATUS_MISS,
    STATUS_CONFLICT
  } status_t;

  typedef enum logic {
    SNOOP_READ,
    SNOOP_INVALID
  } snoop_cmd_t;

  // One cache line, either whole or split into core words
  typedef union packed {
    logic [LINE_W-1:0]                     line;
    logic [WORDS_PER_LINE-1:0][XLEN_W-1:0] words;
  } line_u;

  // ----------------------------------------
  // Requester ports
  // ----------------------------------------
  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } ptw_req_t;

  typedef struct packed {
    logic              valid;
    status_t           status;
    logic [XLEN_W-1:0] data;
  } ptw_resp_t;

  typedef struct packed {
    logic               valid;
    snoop_cmd_t         cmd;
    logic [WAYS-1:0]    ways;
    logic [PADDR_W-1:0] paddr;
  } snoop_req_t;

  typedef struct packed {
    logic                valid;
    status_t             status;
    logic [WAYS-1:0]     ways;
    logic [LINE_B_W-1:0] be;
    line_u               data;
  } snoop_resp_t;

  // Line refill from the miss path
  typedef struct packed {
    logic                    valid;
    logic [$clog2(WAYS)-1:0] way;
    logic [PADDR_W-1:0]      paddr;
    line_u                   data;
  } fill_req_t;

  // ----------------------------------------
  // Array side
  // ----------------------------------------
  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } arr_rd_req_t;

  typedef struct packed {
    logic                    fill_valid;
    logic [$clog2(WAYS)-1:0] fill_way;
    logic [PADDR_W-1:0]      fill_paddr;
    line_u                   fill_data;
    logic                    inv_valid;
    logic [WAYS-1:0]         inv_ways;
    logic [PADDR_W-1:0]      inv_paddr;
  } arr_wr_req_t;

  typedef struct packed {
    logic            hit;
    logic            miss;
    logic [WAYS-1:0] hit_ways;
    line_u           data;
  } arr_rd_resp_t;

  // Request context carried alongside the array lookup
  typedef struct packed {
    logic                  ptw_valid;
    logic                  ptw_conflict;
    logic                  snoop_valid;
    logic                  snoop_rd;
    logic [WORD_SEL_W-1:0] word_sel;
  } s0_tag_t;

endpackage

/* verilog/l1d_cfg_pkg.sv */
// L1 data cache configuration
// Geometry of the two-way array and the address field widths used to
// slice a physical address into tag, index and offset

package l1d_cfg_pkg;

  // ----------------------------------------
  // Word and line sizes
  // ----------------------------------------
  localparam int PADDR_W        = 32;
  localparam int XLEN_W         = 32;
  localparam int LINE_W         = 128;
  localparam int LINE_B_W       = LINE_W / 8;
  localparam int WORDS_PER_LINE = LINE_W / XLEN_W;

  // ----------------------------------------
  // Array organisation
  // ----------------------------------------
  localparam int WAYS = 2;
  localparam int SETS = 16;

  // Address split: | tag | index | offset |
  localparam int OFFSET_W   = $clog2(LINE_B_W);
  localparam int INDEX_W    = $clog2(SETS);
  localparam int TAG_W      = PADDR_W - INDEX_W - OFFSET_W;

  // Walker picks one core word out of the line
  localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

endpackage
